/* video_config.svh */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// =========================================================================
// Display timing defaults, 1280x1024 at 60 Hz with a 108 MHz dot clock
// =========================================================================
`define VIDEO_HORZ_BACK_PORCH   248
`define VIDEO_HORZ_VISIBLE      1280
`define VIDEO_HORZ_FRONT_PORCH  48
`define VIDEO_HORZ_SYNC         112

`define VIDEO_VERT_BACK_PORCH   38
`define VIDEO_VERT_VISIBLE      1024
`define VIDEO_VERT_FRONT_PORCH  1
`define VIDEO_VERT_SYNC         3

// Character cell in pixels
`define VIDEO_CHAR_WIDTH        16
`define VIDEO_CHAR_HEIGHT       20

// External memory, word addressed
`define VIDEO_ADDR_WIDTH        23
`define VIDEO_DATA_WIDTH        32

// Frame counter and the bit that blinks the text cursor
`define VIDEO_FRAME_BITS        10
`define VIDEO_CURSOR_BLINK_BIT  4

`endif

/* video_pkg.sv */
`default_nettype none

`include "video_config.svh"

package video_pkg;

	typedef logic [3:0] color_index_t;

	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} rgb_t;

	// Element 0 is the leftmost pixel of the cell
	typedef color_index_t [`VIDEO_CHAR_WIDTH-1:0] pixel_group_t;

	// Font row, MSB is the leftmost pixel
	typedef logic [`VIDEO_CHAR_WIDTH-1:0] glyph_row_t;

	typedef logic [`VIDEO_ADDR_WIDTH-1:0] mem_addr_t;

	// One memory word of text
	typedef struct packed {
		color_index_t bg;
		color_index_t fg;
		logic [6:0]   reserved_high;
		logic         inverse;
		logic [1:0]   blink_rate;   // off, slow, normal, fast
		logic [3:0]   reserved_low;
		logic [9:0]   char_code;
	} charattr_t;

	typedef enum logic [1:0] {
		REG_BASE_ADDRESS,
		REG_FIRST_ROW,
		REG_CURSOR,
		REG_RESERVED
	} reg_addr_e;

	// Fixed 16 colour ANSI palette
	function automatic rgb_t ansi_palette(color_index_t index);
		case (index)
			4'd0:    return '{3'd0, 3'd0, 3'd0};
			4'd1:    return '{3'd4, 3'd0, 3'd0};
			4'd2:    return '{3'd0, 3'd4, 3'd0};
			4'd3:    return '{3'd4, 3'd4, 3'd0};
			4'd4:    return '{3'd0, 3'd0, 3'd4};
			4'd5:    return '{3'd4, 3'd0, 3'd4};
			4'd6:    return '{3'd0, 3'd4, 3'd4};
			4'd7:    return '{3'd5, 3'd5, 3'd5};
			4'd8:    return '{3'd2, 3'd2, 3'd2};
			4'd9:    return '{3'd7, 3'd0, 3'd0};
			4'd10:   return '{3'd0, 3'd7, 3'd0};
			4'd11:   return '{3'd7, 3'd7, 3'd0};
			4'd12:   return '{3'd0, 3'd0, 3'd7};
			4'd13:   return '{3'd7, 3'd0, 3'd7};
			4'd14:   return '{3'd0, 3'd7, 3'd7};
			default: return '{3'd7, 3'd7, 3'd7};
		endcase
	endfunction

endpackage

`default_nettype wire

/* video_timing.sv */
`timescale 1ns/100ps
`default_nettype none

`include "video_config.svh"

module video_timing #(
	parameter int HORZ_BACK_PORCH  = `VIDEO_HORZ_BACK_PORCH,
	parameter int HORZ_VISIBLE     = `VIDEO_HORZ_VISIBLE,
	parameter int HORZ_FRONT_PORCH = `VIDEO_HORZ_FRONT_PORCH,
	parameter int HORZ_SYNC        = `VIDEO_HORZ_SYNC,
	parameter int VERT_BACK_PORCH  = `VIDEO_VERT_BACK_PORCH,
	parameter int VERT_VISIBLE     = `VIDEO_VERT_VISIBLE,
	parameter int VERT_FRONT_PORCH = `VIDEO_VERT_FRONT_PORCH,
	parameter int VERT_SYNC        = `VIDEO_VERT_SYNC,
	localparam int HORZ_TOTAL =
		HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH + HORZ_SYNC,
	localparam int VERT_TOTAL =
		VERT_BACK_PORCH + VERT_VISIBLE + VERT_FRONT_PORCH + VERT_SYNC
) (
	input  logic clk,
	input  logic reset,
	output logic [$clog2(HORZ_TOTAL)-1:0] xpos,
	output logic [$clog2(VERT_TOTAL)-1:0] ypos,
	output logic h_visible,
	output logic v_visible,
	output logic line_start,
	output logic preload,
	output logic page,
	output logic [5:0] text_row,
	output logic [4:0] cell_line,
	output logic [`VIDEO_FRAME_BITS-1:0] frame_count,
	output logic hsync,
	output logic vsync
);
	localparam int HORZ_SYNC_START = HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH;
	localparam int VERT_SYNC_START = VERT_BACK_PORCH + VERT_VISIBLE + VERT_FRONT_PORCH;
	localparam int ROWS = (VERT_VISIBLE + `VIDEO_CHAR_HEIGHT - 1) / `VIDEO_CHAR_HEIGHT;

	logic line_end;
	logic [$clog2(VERT_TOTAL)-1:0] ypos_next;

	assign line_end = xpos == HORZ_TOTAL - 1;
	assign ypos_next = (ypos == VERT_TOTAL - 1) ? '0 : ypos + 1'b1;
	assign line_start = xpos == '0;

	assign h_visible = xpos >= HORZ_BACK_PORCH && xpos < HORZ_BACK_PORCH + HORZ_VISIBLE;
	assign v_visible = ypos >= VERT_BACK_PORCH && ypos < VERT_BACK_PORCH + VERT_VISIBLE;

	// Last scanline before each text row
	assign preload = ypos == VERT_BACK_PORCH - 1 ||
		(v_visible && cell_line == `VIDEO_CHAR_HEIGHT - 1 && text_row != ROWS - 1);

	// =========================================================================
	// Pixel and line counters, sync pulses at the end of line and frame
	// =========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			xpos <= '0;
			ypos <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else begin
			xpos <= line_end ? '0 : xpos + 1'b1;
			hsync <= line_end || xpos < HORZ_SYNC_START - 1;
			if (line_end) begin
				ypos <= ypos_next;
				vsync <= ypos_next < VERT_SYNC_START;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			frame_count <= '0;
		else if (line_start && ypos == '0)
			frame_count <= frame_count + 1'b1;
	end

	// =========================================================================
	// Text row and scanline within the cell
	// =========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			text_row <= '0;
			cell_line <= '0;
			page <= 1'b0;
		end else if (line_end) begin
			if (ypos_next == VERT_BACK_PORCH) begin
				text_row <= '0;
				cell_line <= '0;
				page <= ~page;
			end else if (v_visible) begin
				if (cell_line == `VIDEO_CHAR_HEIGHT - 1) begin
					text_row <= text_row + 1'b1;
					cell_line <= '0;
					// Renderer moves to the half just fetched
					page <= ~page;
				end else
					cell_line <= cell_line + 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset) cell_line < `VIDEO_CHAR_HEIGHT)
		else $error("cell_line %0d beyond character height", cell_line);

endmodule

`default_nettype wire

/* video_registers.sv */
`timescale 1ns/100ps
`default_nettype none

`include "video_config.svh"

module video_registers import video_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  reg_addr_e wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,
	output mem_addr_t base_address,
	output mem_addr_t first_row,
	output logic cursor_visible,
	output logic [5:0] cursor_row,
	output logic [6:0] cursor_col
);
	logic request;
	logic [31:0] read_value;

	// New cycle seen, ack goes out on the next edge
	assign request = wb_cyc && wb_stb && !wb_ack;

	always_comb begin
		read_value = '0;
		case (wb_adr)
			REG_BASE_ADDRESS: read_value[`VIDEO_ADDR_WIDTH-1:0] = base_address;
			REG_FIRST_ROW:    read_value[`VIDEO_ADDR_WIDTH-1:0] = first_row;
			REG_CURSOR:       read_value[13:0] = {cursor_visible, cursor_row, cursor_col};
			default:          read_value = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
			base_address <= '0;
			first_row <= '0;
			cursor_visible <= 1'b1;
			cursor_row <= '0;
			cursor_col <= '0;
		end else begin
			wb_ack <= request;
			if (request && wb_we) begin
				case (wb_adr)
					REG_BASE_ADDRESS: base_address <= wb_dat_w[`VIDEO_ADDR_WIDTH-1:0];
					REG_FIRST_ROW:    first_row <= wb_dat_w[`VIDEO_ADDR_WIDTH-1:0];
					REG_CURSOR: begin
						cursor_visible <= wb_dat_w[13];
						cursor_row <= wb_dat_w[12:7];
						cursor_col <= wb_dat_w[6:0];
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (request)
			wb_dat_r <= read_value;
	end

	assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
		else $error("Wishbone ack without a pending cycle");

endmodule

`default_nettype wire

/* line_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module line_ram #(
	parameter type entry_t = logic [31:0],
	parameter int DEPTH = 128
) (
	input  logic clk,
	input  logic wr_en,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	input  entry_t wr_data,
	output entry_t rd_data
);
	entry_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered read, one cycle
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* row_fetcher.sv */
`timescale 1ns/100ps
`default_nettype none

`include "video_config.svh"

module row_fetcher import video_pkg::*; #(
	parameter int COLUMNS = 80,
	parameter int ROWS = 52
) (
	input  logic clk,
	input  logic reset,
	input  logic frame_start,
	input  logic preload,
	input  logic line_start,
	input  logic page,
	input  mem_addr_t base_address,
	input  mem_addr_t first_row,
	output logic rd_request,
	output mem_addr_t rd_address,
	input  logic rd_available,
	input  logic [`VIDEO_DATA_WIDTH-1:0] rd_data,
	output logic buf_wr_en,
	output logic [$clog2(2*COLUMNS)-1:0] buf_wr_addr,
	output charattr_t buf_wr_data
);
	localparam int AW = $clog2(2 * COLUMNS);
	localparam int CW = $clog2(COLUMNS + 1);
	localparam mem_addr_t ROW_SIZE = mem_addr_t'(COLUMNS);
	localparam mem_addr_t PAGE_SIZE = mem_addr_t'(ROWS * COLUMNS);

	mem_addr_t next_row;
	logic [CW-1:0] word_count;
	logic target_half;

	// One burst per preload line, at its first pixel
	assign rd_request = preload && line_start;

	// Wrap back to the top of the page
	assign next_row = (rd_address + ROW_SIZE >= base_address + PAGE_SIZE) ?
		base_address : rd_address + ROW_SIZE;

	always_ff @(posedge clk) begin
		if (reset)
			rd_address <= '0;
		else if (frame_start)
			rd_address <= first_row;
		else if (rd_request)
			rd_address <= next_row;
	end

	// =========================================================================
	// Arriving words go into the half the renderer is not reading
	// =========================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			word_count <= CW'(COLUMNS);
			target_half <= 1'b0;
			buf_wr_en <= 1'b0;
		end else begin
			buf_wr_en <= 1'b0;
			if (rd_request) begin
				word_count <= '0;
				target_half <= ~page;
			end else if (rd_available && word_count != CW'(COLUMNS)) begin
				buf_wr_en <= 1'b1;
				word_count <= word_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		buf_wr_addr <= target_half ? AW'(COLUMNS) + AW'(word_count) : AW'(word_count);
		buf_wr_data <= charattr_t'(rd_data);
	end

	assert property (@(posedge clk) disable iff (reset) word_count <= CW'(COLUMNS))
		else $error("Row fetch counted %0d words", word_count);

endmodule

`default_nettype wire

/* glyph_renderer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "video_config.svh"

module glyph_renderer import video_pkg::*; #(
	parameter int COLUMNS = 80
) (
	input  logic clk,
	input  logic reset,
	input  logic line_start,
	input  logic v_visible,
	input  logic page,
	input  logic [4:0] cell_line,
	input  logic [`VIDEO_FRAME_BITS-1:0] frame_count,
	output logic [$clog2(2*COLUMNS)-1:0] buf_rd_addr,
	input  charattr_t buf_rd_data,
	output logic [14:0] font_address,
	input  glyph_row_t char_row_bitmap,
	output logic pix_wr_en,
	output logic [$clog2(COLUMNS)-1:0] pix_wr_addr,
	output pixel_group_t pix_wr_data
);
	localparam int AW = $clog2(2 * COLUMNS);
	localparam int PW = $clog2(COLUMNS);

	// Steps 3 and 4 wait on the font ROM
	localparam logic [2:0]
		STEP_LATCH  = 3'd1,
		STEP_DECODE = 3'd2,
		STEP_EXPAND = 3'd5,
		STEP_NEXT   = 3'd7;

	logic [1:0] lead;
	logic running;
	logic [2:0] step;
	logic [PW-1:0] col;
	charattr_t attr;
	color_index_t fg;
	color_index_t bg;
	color_index_t fg_next;
	color_index_t bg_next;
	logic blink_hide;

	assign buf_rd_addr = page ? AW'(COLUMNS) + AW'(col) : AW'(col);

	// =========================================================================
	// Attribute decode
	// =========================================================================
	always_comb begin
		case (attr.blink_rate)
			2'd1:    blink_hide = !frame_count[5];
			2'd2:    blink_hide = !frame_count[4];
			2'd3:    blink_hide = !frame_count[3];
			default: blink_hide = 1'b0;
		endcase
		fg_next = attr.inverse ? attr.bg : attr.fg;
		bg_next = attr.inverse ? attr.fg : attr.bg;
		// Blinking text vanishes into the background
		if (blink_hide)
			fg_next = bg_next;
	end

	// =========================================================================
	// Cell sequencer, first cell at xpos 4
	// =========================================================================
	always_ff @(posedge clk) begin
		if (reset || line_start) begin
			lead <= 2'd3;
			running <= 1'b0;
			step <= '0;
			col <= '0;
			pix_wr_en <= 1'b0;
		end else begin
			pix_wr_en <= 1'b0;
			if (lead != '0) begin
				lead <= lead - 1'b1;
				running <= lead == 2'd1 && v_visible;
			end
			if (running) begin
				step <= step + 1'b1;
				if (step == STEP_EXPAND)
					pix_wr_en <= 1'b1;
				if (step == STEP_NEXT) begin
					col <= col + 1'b1;
					if (col == PW'(COLUMNS - 1))
						running <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		case (step)
			STEP_LATCH: attr <= buf_rd_data;
			STEP_DECODE: begin
				fg <= fg_next;
				bg <= bg_next;
				font_address <= 15'(attr.char_code) * 15'(`VIDEO_CHAR_HEIGHT) + 15'(cell_line);
			end
			STEP_EXPAND: begin
				pix_wr_addr <= col;
				for (int i = 0; i < `VIDEO_CHAR_WIDTH; i++)
					pix_wr_data[i] <= char_row_bitmap[`VIDEO_CHAR_WIDTH - 1 - i] ? fg : bg;
			end
			default: ;
		endcase
	end

	assert property (@(posedge clk) disable iff (reset)
		pix_wr_en |-> 32'(pix_wr_addr) < COLUMNS)
		else $error("Pixel group written past column %0d", COLUMNS - 1);

endmodule

`default_nettype wire

/* pixel_output.sv */
`timescale 1ns/100ps
`default_nettype none

`include "video_config.svh"

module pixel_output import video_pkg::*; #(
	parameter int HORZ_BACK_PORCH = `VIDEO_HORZ_BACK_PORCH,
	parameter int HORZ_TOTAL = 1688,
	parameter int COLUMNS = 80
) (
	input  logic clk,
	input  logic reset,
	input  logic h_visible,
	input  logic v_visible,
	input  logic [$clog2(HORZ_TOTAL)-1:0] xpos,
	input  logic [5:0] text_row,
	input  logic [`VIDEO_FRAME_BITS-1:0] frame_count,
	input  logic cursor_visible,
	input  logic [5:0] cursor_row,
	input  logic [6:0] cursor_col,
	output logic [$clog2(COLUMNS)-1:0] pix_rd_addr,
	input  pixel_group_t pix_rd_data,
	output logic [2:0] pixel_red,
	output logic [2:0] pixel_green,
	output logic [2:0] pixel_blue
);
	localparam int XW = $clog2(HORZ_TOTAL);
	localparam int PW = $clog2(COLUMNS);
	localparam int GROUP_SHIFT = $clog2(`VIDEO_CHAR_WIDTH);

	logic [XW-1:0] column;
	logic [XW-1:0] column_ahead;
	color_index_t index;
	rgb_t color;
	logic cursor_cell;

	// Line RAM is read one pixel ahead of display
	assign column = xpos - XW'(HORZ_BACK_PORCH);
	assign column_ahead = column + 1'b1;
	assign pix_rd_addr = PW'(column_ahead >> GROUP_SHIFT);

	assign index = pix_rd_data[column[GROUP_SHIFT-1:0]];
	assign color = ansi_palette(index);

	assign cursor_cell = cursor_visible && frame_count[`VIDEO_CURSOR_BLINK_BIT] &&
		text_row == cursor_row && 32'(column >> GROUP_SHIFT) == 32'(cursor_col);

	always_ff @(posedge clk) begin
		if (reset || !(h_visible && v_visible)) begin
			pixel_red <= '0;
			pixel_green <= '0;
			pixel_blue <= '0;
		end else begin
			{pixel_red, pixel_green, pixel_blue} <= cursor_cell ? ~color : color;
		end
	end

endmodule

`default_nettype wire

/* video_controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "video_config.svh"

module video_controller import video_pkg::*; #(
	parameter int HORZ_BACK_PORCH  = `VIDEO_HORZ_BACK_PORCH,
	parameter int HORZ_VISIBLE     = `VIDEO_HORZ_VISIBLE,
	parameter int HORZ_FRONT_PORCH = `VIDEO_HORZ_FRONT_PORCH,
	parameter int HORZ_SYNC        = `VIDEO_HORZ_SYNC,
	parameter int VERT_BACK_PORCH  = `VIDEO_VERT_BACK_PORCH,
	parameter int VERT_VISIBLE     = `VIDEO_VERT_VISIBLE,
	parameter int VERT_FRONT_PORCH = `VIDEO_VERT_FRONT_PORCH,
	parameter int VERT_SYNC        = `VIDEO_VERT_SYNC
) (
	input  logic clk,
	input  logic reset,

	// Wishbone register slave
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  reg_addr_e wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack,

	// Memory read port
	output logic rd_request,
	output mem_addr_t rd_address,
	input  logic rd_available,
	input  logic [`VIDEO_DATA_WIDTH-1:0] rd_data,

	// Font ROM
	output logic [14:0] font_address,
	input  glyph_row_t char_row_bitmap,

	// VGA
	output logic hsync,
	output logic vsync,
	output logic [2:0] pixel_red,
	output logic [2:0] pixel_green,
	output logic [2:0] pixel_blue
);
	localparam int HORZ_TOTAL =
		HORZ_BACK_PORCH + HORZ_VISIBLE + HORZ_FRONT_PORCH + HORZ_SYNC;
	localparam int VERT_TOTAL =
		VERT_BACK_PORCH + VERT_VISIBLE + VERT_FRONT_PORCH + VERT_SYNC;
	localparam int COLUMNS = HORZ_VISIBLE / `VIDEO_CHAR_WIDTH;
	localparam int ROWS = (VERT_VISIBLE + `VIDEO_CHAR_HEIGHT - 1) / `VIDEO_CHAR_HEIGHT;

	logic [$clog2(HORZ_TOTAL)-1:0] xpos;
	logic [$clog2(VERT_TOTAL)-1:0] ypos;
	logic h_visible;
	logic v_visible;
	logic line_start;
	logic frame_start;
	logic preload;
	logic page;
	logic [5:0] text_row;
	logic [4:0] cell_line;
	logic [`VIDEO_FRAME_BITS-1:0] frame_count;

	mem_addr_t base_address;
	mem_addr_t first_row;
	logic cursor_visible;
	logic [5:0] cursor_row;
	logic [6:0] cursor_col;

	logic buf_wr_en;
	logic [$clog2(2*COLUMNS)-1:0] buf_wr_addr;
	logic [$clog2(2*COLUMNS)-1:0] buf_rd_addr;
	charattr_t buf_wr_data;
	charattr_t buf_rd_data;

	logic pix_wr_en;
	logic [$clog2(COLUMNS)-1:0] pix_wr_addr;
	logic [$clog2(COLUMNS)-1:0] pix_rd_addr;
	pixel_group_t pix_wr_data;
	pixel_group_t pix_rd_data;

	assign frame_start = line_start && ypos == '0;

	video_timing #(
		.HORZ_BACK_PORCH(HORZ_BACK_PORCH), .HORZ_VISIBLE(HORZ_VISIBLE),
		.HORZ_FRONT_PORCH(HORZ_FRONT_PORCH), .HORZ_SYNC(HORZ_SYNC),
		.VERT_BACK_PORCH(VERT_BACK_PORCH), .VERT_VISIBLE(VERT_VISIBLE),
		.VERT_FRONT_PORCH(VERT_FRONT_PORCH), .VERT_SYNC(VERT_SYNC)
	) timing (.*);

	video_registers registers (.*);

	row_fetcher #(.COLUMNS(COLUMNS), .ROWS(ROWS)) fetcher (.*);

	// Two text rows, one being fetched while the other is drawn
	line_ram #(.entry_t(charattr_t), .DEPTH(2 * COLUMNS)) row_buffer (
		.clk(clk),
		.wr_en(buf_wr_en),
		.wr_addr(buf_wr_addr),
		.rd_addr(buf_rd_addr),
		.wr_data(buf_wr_data),
		.rd_data(buf_rd_data)
	);

	glyph_renderer #(.COLUMNS(COLUMNS)) renderer (.*);

	line_ram #(.entry_t(pixel_group_t), .DEPTH(COLUMNS)) pixel_line (
		.clk(clk),
		.wr_en(pix_wr_en),
		.wr_addr(pix_wr_addr),
		.rd_addr(pix_rd_addr),
		.wr_data(pix_wr_data),
		.rd_data(pix_rd_data)
	);

	pixel_output #(
		.HORZ_BACK_PORCH(HORZ_BACK_PORCH),
		.HORZ_TOTAL(HORZ_TOTAL),
		.COLUMNS(COLUMNS)
	) output_stage (.*);

endmodule

`default_nettype wire

/* tb_video_controller.sv */
`timescale 1ns/100ps
`default_nettype none

`include "video_config.svh"

module tb_video_controller import video_pkg::*; ();

	// Small screen, 4 columns by 2 text rows
	localparam int H_BACK = 40;
	localparam int H_VISIBLE = 64;
	localparam int H_FRONT = 8;
	localparam int H_SYNC = 8;
	localparam int V_BACK = 3;
	localparam int V_VISIBLE = 40;
	localparam int V_FRONT = 1;
	localparam int V_SYNC = 2;
	localparam int H_TOTAL = H_BACK + H_VISIBLE + H_FRONT + H_SYNC;
	localparam int V_TOTAL = V_BACK + V_VISIBLE + V_FRONT + V_SYNC;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int CHAR_W = `VIDEO_CHAR_WIDTH;
	localparam int CHAR_H = `VIDEO_CHAR_HEIGHT;
	localparam int COLUMNS = H_VISIBLE / CHAR_W;
	localparam int MEM_WORDS = 16;
	localparam int ENTRIES = 4;
	localparam logic [1:0] CHECK_PIXELS = 2'b01;
	localparam logic [1:0] CHECK_FETCH = 2'b10;
	localparam logic [31:0] ADDR_MASK = 32'h007f_ffff;
	localparam logic [31:0] CURSOR_MASK = 32'h0000_3fff;

	typedef struct {
		logic [22:0] base;
		logic [22:0] first_row;
		logic [22:0] row1_address;
		logic [13:0] cursor;
		int frames;
		logic [1:0] checks;
	} test_entry_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic wb_cyc = 1'b0;
	logic wb_stb = 1'b0;
	logic wb_we = 1'b0;
	reg_addr_e wb_adr = REG_BASE_ADDRESS;
	logic [31:0] wb_dat_w = '0;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	logic rd_request;
	mem_addr_t rd_address;
	logic rd_available = 1'b0;
	logic [`VIDEO_DATA_WIDTH-1:0] rd_data = '0;
	logic [14:0] font_address;
	glyph_row_t char_row_bitmap = '0;
	logic hsync;
	logic vsync;
	logic [2:0] pixel_red;
	logic [2:0] pixel_green;
	logic [2:0] pixel_blue;

	test_entry_t stimulus [ENTRIES];
	charattr_t memory [MEM_WORDS];

	// Configuration the checker compares against
	logic [1:0] checking = '0;
	int cur_first = 0;
	int cur_row1 = 0;
	logic [13:0] cur_cursor = '0;

	// Beam position recovered from the sync outputs
	int tx = 0;
	int ty = 0;
	int tframe = 0;
	logic started = 1'b0;
	logic reset_seen = 1'b0;
	logic last_hsync = 1'b1;
	logic last_vsync = 1'b1;

	int cursor_hits = 0;
	int fetch_checks = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	int total_frames = 0;
	int first_frame = 0;

	int burst_left = 0;
	int burst_addr = 0;
	int gap = 0;
	glyph_row_t font_stage = '0;

	video_controller #(
		.HORZ_BACK_PORCH(H_BACK), .HORZ_VISIBLE(H_VISIBLE),
		.HORZ_FRONT_PORCH(H_FRONT), .HORZ_SYNC(H_SYNC),
		.VERT_BACK_PORCH(V_BACK), .VERT_VISIBLE(V_VISIBLE),
		.VERT_FRONT_PORCH(V_FRONT), .VERT_SYNC(V_SYNC)
	) dut (.*);

	initial begin
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	// =========================================================================
	// Models of font ROM and pixel rules
	// =========================================================================
	function automatic glyph_row_t font_row(input logic [14:0] address);
		logic [31:0] mixed;
		mixed = {17'd0, address} * 32'h9e37_79b1;
		return mixed[31:16] ^ mixed[15:0];
	endfunction

	function automatic logic cursor_shown(input int column, input int line,
		input logic [31:0] frame);
		return cur_cursor[13] && frame[`VIDEO_CURSOR_BLINK_BIT] &&
			line / CHAR_H == int'(cur_cursor[12:7]) &&
			column / CHAR_W == int'(cur_cursor[6:0]);
	endfunction

	function automatic rgb_t expected_pixel(input int column, input int line,
		input logic [31:0] frame);
		int address;
		charattr_t word;
		color_index_t fg;
		color_index_t bg;
		logic hide;
		glyph_row_t glyph;
		rgb_t color;
		address = (line / CHAR_H == 0) ? cur_first : cur_row1;
		word = memory[(address + column / CHAR_W) % MEM_WORDS];
		fg = word.inverse ? word.bg : word.fg;
		bg = word.inverse ? word.fg : word.bg;
		case (word.blink_rate)
			2'd1:    hide = !frame[5];
			2'd2:    hide = !frame[4];
			2'd3:    hide = !frame[3];
			default: hide = 1'b0;
		endcase
		if (hide)
			fg = bg;
		glyph = font_row(15'(word.char_code * CHAR_H + line % CHAR_H));
		color = ansi_palette(glyph[CHAR_W - 1 - column % CHAR_W] ? fg : bg);
		if (cursor_shown(column, line, frame))
			color = rgb_t'(~color);
		return color;
	endfunction

	// Font data two cycles behind the address
	always @(negedge clk) begin
		char_row_bitmap = font_stage;
		font_stage = font_row(font_address);
	end

	// Burst memory with random gaps between words
	always @(negedge clk) begin
		if (rd_request === 1'b1) begin
			burst_left = COLUMNS;
			burst_addr = int'(rd_address);
			gap = $urandom_range(3, 0);
			rd_available = 1'b0;
		end else if (burst_left > 0 && gap == 0) begin
			rd_available = 1'b1;
			rd_data = memory[burst_addr % MEM_WORDS];
			burst_addr++;
			burst_left--;
			gap = $urandom_range(3, 0);
		end else begin
			rd_available = 1'b0;
			if (gap > 0)
				gap--;
		end
	end

	// =========================================================================
	// Beam tracking and output checks, sampled before each rising edge
	// =========================================================================
	always @(posedge clk) begin : output_checks
		logic [8:0] rgb;
		rgb_t expected;
		int column;
		int line;
		rgb = {pixel_red, pixel_green, pixel_blue};
		if (reset) begin
			assert (!reset_seen || rgb === 9'd0) else abort_run($sformatf(
				"FAILED at %0t: RGB %h while in reset", $time, rgb));
			reset_seen = 1'b1;
			started = 1'b0;
			last_hsync = 1'b1;
			last_vsync = 1'b1;
		end else begin
			if (!started) begin
				tx = 0;
				ty = 0;
				tframe = 1;
				started = 1'b1;
			end else if (hsync && !last_hsync) begin
				assert (tx == H_TOTAL - 1) else abort_run($sformatf(
					"FAILED at %0t: line lasted %0d cycles, expected %0d", $time, tx + 1, H_TOTAL));
				tx = 0;
				if (vsync && !last_vsync) begin
					assert (ty == V_TOTAL - 1) else abort_run($sformatf(
						"FAILED at %0t: frame lasted %0d lines, expected %0d", $time, ty + 1, V_TOTAL));
					ty = 0;
					tframe++;
				end else
					ty++;
			end else
				tx++;
			last_hsync = hsync;
			last_vsync = vsync;

			assert (hsync === (tx < H_TOTAL - H_SYNC)) else abort_run($sformatf(
				"FAILED at %0t: hsync is %b at x %0d", $time, hsync, tx));
			assert (vsync === (ty < V_TOTAL - V_SYNC)) else abort_run($sformatf(
				"FAILED at %0t: vsync is %b at line %0d", $time, vsync, ty));

			// Column c shows one cycle after back porch plus c
			column = tx - H_BACK - 1;
			line = ty - V_BACK;
			if (column >= 0 && column < H_VISIBLE && line >= 0 && line < V_VISIBLE) begin
				if (checking[0]) begin
					expected = expected_pixel(column, line, tframe);
					assert (rgb === expected) else abort_run($sformatf(
						"FAILED at %0t: pixel %0d,%0d of frame %0d is %h, expected %h",
						$time, column, line, tframe, rgb, expected));
					if (cursor_shown(column, line, tframe))
						cursor_hits++;
				end
			end else begin
				assert (rgb === 9'd0) else abort_run($sformatf(
					"FAILED at %0t: RGB %h outside the visible area at %0d,%0d", $time, rgb, tx, ty));
			end

			if (rd_request === 1'b1) begin
				assert (tx == 0 && (ty == V_BACK - 1 || ty == V_BACK + CHAR_H - 1))
					else abort_run($sformatf(
						"FAILED at %0t: read request at x %0d line %0d", $time, tx, ty));
				if (checking[1]) begin
					assert (rd_address === mem_addr_t'((ty == V_BACK - 1) ? cur_first : cur_row1))
						else abort_run($sformatf(
							"FAILED at %0t: read address %h on line %0d", $time, rd_address, ty));
					fetch_checks++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit)
			abort_run($sformatf("Timeout, the run did not end within %0d cycles", cycle_limit));
	end

	// =========================================================================
	// Wishbone master
	// =========================================================================
	task automatic bus_cycle(input reg_addr_e adr, input logic write, input logic [31:0] data,
		output logic [31:0] read_data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = write;
		wb_adr = adr;
		wb_dat_w = data;
		@(negedge clk);
		assert (wb_ack === 1'b1) else abort_run($sformatf(
			"No Wishbone acknowledge in the cycle after a request to %s", adr.name()));
		read_data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
		assert (wb_ack === 1'b0) else abort_run($sformatf(
			"FAILED at %0t: Wishbone acknowledge held longer than one cycle", $time));
	endtask

	task automatic write_and_verify(input reg_addr_e adr, input logic [31:0] value,
		input logic [31:0] mask);
		logic [31:0] read_data;
		bus_cycle(adr, 1'b1, ($urandom & ~mask) | (value & mask), read_data);
		bus_cycle(adr, 1'b0, 32'd0, read_data);
		assert (read_data === (value & mask)) else abort_run($sformatf(
			"FAILED at %0t: register %s reads %h, expected %h",
			$time, adr.name(), read_data, value & mask));
	endtask

	// =========================================================================
	// Stimulus table
	// =========================================================================
	initial begin
		void'($urandom(32'h78f4_30ed));

		// base, first row, row 1 address, cursor {visible,row,col}, frames, checks
		stimulus[0] = '{23'd0, 23'd0, 23'd4, 14'h2000, 2, CHECK_PIXELS};
		stimulus[1] = '{23'd8, 23'd12, 23'd8, 14'h2082, 4, CHECK_PIXELS | CHECK_FETCH};
		stimulus[2] = '{23'd4, 23'd4, 23'd8, 14'h0083, 8, CHECK_PIXELS | CHECK_FETCH};
		stimulus[3] = '{23'd2, 23'd6, 23'd2, 14'h2003, 8, CHECK_PIXELS | CHECK_FETCH};

		for (int i = 0; i < MEM_WORDS; i++)
			memory[i] = charattr_t'($urandom);
		for (int i = 0; i < ENTRIES; i++)
			total_frames += stimulus[i].frames;
		cycle_limit = total_frames * FRAME_CYCLES * 2;

		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		write_and_verify(REG_RESERVED, $urandom, 32'd0);

		for (int i = 0; i < ENTRIES; i++) begin
			checking = '0;
			write_and_verify(REG_BASE_ADDRESS, 32'(stimulus[i].base), ADDR_MASK);
			write_and_verify(REG_FIRST_ROW, 32'(stimulus[i].first_row), ADDR_MASK);
			write_and_verify(REG_CURSOR, 32'(stimulus[i].cursor), CURSOR_MASK);
			cur_first = int'(stimulus[i].first_row);
			cur_row1 = int'(stimulus[i].row1_address);
			cur_cursor = stimulus[i].cursor;

			// New first row is loaded at the next frame start
			first_frame = tframe + 1;
			while (tframe != first_frame)
				@(negedge clk);
			checking = stimulus[i].checks;
			while (tframe != first_frame + stimulus[i].frames)
				@(negedge clk);
		end
		checking = '0;

		if (cursor_hits > 0 && fetch_checks > 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else
			abort_run("The cursor inversion or the row fetch address was never exercised");
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
video_pkg.sv
video_timing.sv
video_registers.sv
line_ram.sv
row_fetcher.sv
glyph_renderer.sv
pixel_output.sv
video_controller.sv
tb_video_controller.sv

/* Bender.yml */
package:
  name: video_controller

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - video_pkg.sv
      - video_timing.sv
      - video_registers.sv
      - line_ram.sv
      - row_fetcher.sv
      - glyph_renderer.sv
      - pixel_output.sv
      - video_controller.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_video_controller.sv
